//--- rv_decode_pkg.sv
package rv_decode_pkg;

    localparam int XLEN      = 32;
    localparam int PC_W      = 30;
    localparam int REG_IDX_W = 5;
    localparam int CSR_IDX_W = 12;

    // funct7 patterns for OP and the immediate shifts
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    typedef enum logic [6:0] {
        OPC_LOAD     = 7'b0000011,
        OPC_MISC_MEM = 7'b0001111,
        OPC_OP_IMM   = 7'b0010011,
        OPC_AUIPC    = 7'b0010111,
        OPC_STORE    = 7'b0100011,
        OPC_OP       = 7'b0110011,
        OPC_LUI      = 7'b0110111,
        OPC_BRANCH   = 7'b1100011,
        OPC_JALR     = 7'b1100111,
        OPC_JAL      = 7'b1101111,
        OPC_SYSTEM   = 7'b1110011
    } rv_opcode_e;

    typedef enum logic [5:0] {
        INSTR_ILLEGAL,
        INSTR_LB, INSTR_LH, INSTR_LW, INSTR_LBU, INSTR_LHU,
        INSTR_ADDI, INSTR_SLLI, INSTR_SLTI, INSTR_SLTIU,
        INSTR_XORI, INSTR_SRLI, INSTR_SRAI, INSTR_ORI, INSTR_ANDI,
        INSTR_AUIPC,
        INSTR_SB, INSTR_SH, INSTR_SW,
        INSTR_ADD, INSTR_SUB, INSTR_SLL, INSTR_SLT, INSTR_SLTU,
        INSTR_XOR, INSTR_SRL, INSTR_SRA, INSTR_OR, INSTR_AND,
        INSTR_LUI,
        INSTR_BEQ, INSTR_BNE, INSTR_BLT, INSTR_BGE, INSTR_BLTU, INSTR_BGEU,
        INSTR_JALR,
        INSTR_JAL,
        INSTR_FENCE, INSTR_FENCE_I,
        INSTR_CSRRW, INSTR_CSRRS, INSTR_CSRRC,
        INSTR_CSRRWI, INSTR_CSRRSI, INSTR_CSRRCI
    } rv_instr_e;

    // bit 4 set only for the arithmetic right shift
    typedef enum logic [4:0] {
        ALU_ADD   = 5'b00000,
        ALU_SUB   = 5'b00001,
        ALU_XOR   = 5'b00010,
        ALU_OR    = 5'b00011,
        ALU_AND   = 5'b00100,
        ALU_SHL   = 5'b00101,
        ALU_SHR_L = 5'b00110,
        ALU_SHR_A = 5'b10110,
        ALU_EQ    = 5'b01000,
        ALU_NEQ   = 5'b01001,
        ALU_LTS   = 5'b01010,
        ALU_LTU   = 5'b01011,
        ALU_NLTS  = 5'b01100,
        ALU_NLTU  = 5'b01101
    } alu_ctrl_e;

    typedef enum logic [1:0] {
        RES_ALU    = 2'd0,
        RES_MEMORY = 2'd1,
        RES_PC_P4  = 2'd2
    } res_src_e;

    typedef enum logic {
        OP1_REG = 1'b0,
        OP1_PC  = 1'b1
    } op1_sel_e;

    typedef enum logic {
        OP2_REG = 1'b0,
        OP2_IMM = 1'b1
    } op2_sel_e;

    typedef struct packed {
        logic [XLEN-1:0] imm_i;
        logic [XLEN-1:0] imm_s;
        logic [XLEN-1:0] imm_b;
        logic [XLEN-1:0] imm_u;
        logic [XLEN-1:0] imm_j;
    } imm_set_t;

    typedef struct packed {
        logic [REG_IDX_W-1:0] rs1;
        logic [REG_IDX_W-1:0] rs2;
        logic [REG_IDX_W-1:0] rd;
    } reg_idx_t;

    typedef struct packed {
        logic                 reg_write;
        logic                 mem_read;
        logic                 mem_write;
        res_src_e             res_src;
        logic                 jump;
        logic                 branch;
        logic                 pc_sel;
        op1_sel_e             op1_sel;
        op2_sel_e             op2_sel;
        logic [2:0]           funct3;
        alu_ctrl_e            alu_ctrl;
        logic [CSR_IDX_W-1:0] csr_idx;
        logic                 csr_read;
        logic                 csr_write;
    } decode_ctrl_t;

endpackage

//--- rv_instr_classify.sv
`timescale 1ns/1ps

module rv_instr_classify
    import rv_decode_pkg::*;
(
    input  logic [XLEN-1:0] i_instr,
    output rv_instr_e       o_instr
);

    rv_opcode_e opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       full_len;

    assign opcode   = rv_opcode_e'(i_instr[6:0]);
    assign funct3   = i_instr[14:12];
    assign funct7   = i_instr[31:25];
    // compressed words have anything but 11 here
    assign full_len = (i_instr[1:0] == 2'b11);

    always_comb
    begin
        o_instr = INSTR_ILLEGAL;
        if (full_len)
        begin
            case (opcode)
                OPC_LOAD:
                begin
                    case (funct3)
                        3'b000: o_instr = INSTR_LB;
                        3'b001: o_instr = INSTR_LH;
                        3'b010: o_instr = INSTR_LW;
                        3'b100: o_instr = INSTR_LBU;
                        3'b101: o_instr = INSTR_LHU;
                        default: o_instr = INSTR_ILLEGAL;
                    endcase
                end
                OPC_MISC_MEM:
                begin
                    if (funct3 == 3'b000)
                        o_instr = INSTR_FENCE;
                    else if (funct3 == 3'b001)
                        o_instr = INSTR_FENCE_I;
                end
                OPC_OP_IMM:
                begin
                    case (funct3)
                        3'b000: o_instr = INSTR_ADDI;
                        3'b010: o_instr = INSTR_SLTI;
                        3'b011: o_instr = INSTR_SLTIU;
                        3'b100: o_instr = INSTR_XORI;
                        3'b110: o_instr = INSTR_ORI;
                        3'b111: o_instr = INSTR_ANDI;
                        3'b001:
                        begin
                            if (funct7 == F7_BASE)
                                o_instr = INSTR_SLLI;
                        end
                        default:
                        begin
                            // funct3 101, shamt field shares funct7
                            if (funct7 == F7_BASE)
                                o_instr = INSTR_SRLI;
                            else if (funct7 == F7_ALT)
                                o_instr = INSTR_SRAI;
                        end
                    endcase
                end
                OPC_AUIPC: o_instr = INSTR_AUIPC;
                OPC_STORE:
                begin
                    case (funct3)
                        3'b000: o_instr = INSTR_SB;
                        3'b001: o_instr = INSTR_SH;
                        3'b010: o_instr = INSTR_SW;
                        default: o_instr = INSTR_ILLEGAL;
                    endcase
                end
                OPC_OP:
                begin
                    case ({funct7, funct3})
                        {F7_BASE, 3'b000}: o_instr = INSTR_ADD;
                        {F7_ALT,  3'b000}: o_instr = INSTR_SUB;
                        {F7_BASE, 3'b001}: o_instr = INSTR_SLL;
                        {F7_BASE, 3'b010}: o_instr = INSTR_SLT;
                        {F7_BASE, 3'b011}: o_instr = INSTR_SLTU;
                        {F7_BASE, 3'b100}: o_instr = INSTR_XOR;
                        {F7_BASE, 3'b101}: o_instr = INSTR_SRL;
                        {F7_ALT,  3'b101}: o_instr = INSTR_SRA;
                        {F7_BASE, 3'b110}: o_instr = INSTR_OR;
                        {F7_BASE, 3'b111}: o_instr = INSTR_AND;
                        default: o_instr = INSTR_ILLEGAL;
                    endcase
                end
                OPC_LUI: o_instr = INSTR_LUI;
                OPC_BRANCH:
                begin
                    case (funct3)
                        3'b000: o_instr = INSTR_BEQ;
                        3'b001: o_instr = INSTR_BNE;
                        3'b100: o_instr = INSTR_BLT;
                        3'b101: o_instr = INSTR_BGE;
                        3'b110: o_instr = INSTR_BLTU;
                        3'b111: o_instr = INSTR_BGEU;
                        default: o_instr = INSTR_ILLEGAL;
                    endcase
                end
                OPC_JALR:
                begin
                    if (funct3 == 3'b000)
                        o_instr = INSTR_JALR;
                end
                OPC_JAL: o_instr = INSTR_JAL;
                OPC_SYSTEM:
                begin
                    // ecall and ebreak fall through as illegal
                    case (funct3)
                        3'b001: o_instr = INSTR_CSRRW;
                        3'b010: o_instr = INSTR_CSRRS;
                        3'b011: o_instr = INSTR_CSRRC;
                        3'b101: o_instr = INSTR_CSRRWI;
                        3'b110: o_instr = INSTR_CSRRSI;
                        3'b111: o_instr = INSTR_CSRRCI;
                        default: o_instr = INSTR_ILLEGAL;
                    endcase
                end
                default: o_instr = INSTR_ILLEGAL;
            endcase
        end
    end

endmodule

//--- rv_imm_gen.sv
`timescale 1ns/1ps

module rv_imm_gen
    import rv_decode_pkg::*;
(
    input  logic [XLEN-1:0] i_instr,
    output imm_set_t        o_imms
);

    logic sign;

    assign sign = i_instr[31];

    // I type, loads, jalr and op-imm
    assign o_imms.imm_i = {
        {21{sign}},
        i_instr[30:20]
    };

    // S type splits the offset around rd
    assign o_imms.imm_s = {
        {21{sign}},
        i_instr[30:25],
        i_instr[11:7]
    };

    assign o_imms.imm_b = {
        {20{sign}},
        i_instr[7],
        i_instr[30:25],
        i_instr[11:8],
        1'b0
    };

    assign o_imms.imm_u = {
        i_instr[31:12],
        12'b0
    };

    assign o_imms.imm_j = {
        {12{sign}},
        i_instr[19:12],
        i_instr[20],
        i_instr[30:21],
        1'b0
    };

endmodule

//--- rv_ctrl_gen.sv
`timescale 1ns/1ps

module rv_ctrl_gen
    import rv_decode_pkg::*;
(
    input  logic [XLEN-1:0] i_instr,
    input  rv_instr_e       i_op,
    input  imm_set_t        i_imms,
    output reg_idx_t        o_regs,
    output logic [XLEN-1:0] o_imm,
    output decode_ctrl_t    o_ctrl
);

    logic                 is_load;
    logic                 is_store;
    logic                 is_op_imm;
    logic                 is_op;
    logic                 is_branch;
    logic                 is_jump;
    logic                 is_upper;
    logic                 csr_rw;
    logic                 csr_sc;
    logic [REG_IDX_W-1:0] rd_f;
    logic [REG_IDX_W-1:0] rs1_f;
    alu_ctrl_e            alu_op;

    assign rd_f  = i_instr[11:7];
    assign rs1_f = i_instr[19:15];

    assign is_load   = i_op inside {INSTR_LB, INSTR_LH, INSTR_LW, INSTR_LBU, INSTR_LHU};
    assign is_store  = i_op inside {INSTR_SB, INSTR_SH, INSTR_SW};
    assign is_op_imm = i_op inside {INSTR_ADDI, INSTR_SLLI, INSTR_SLTI, INSTR_SLTIU,
                                    INSTR_XORI, INSTR_SRLI, INSTR_SRAI, INSTR_ORI,
                                    INSTR_ANDI};
    assign is_op     = i_op inside {INSTR_ADD, INSTR_SUB, INSTR_SLL, INSTR_SLT, INSTR_SLTU,
                                    INSTR_XOR, INSTR_SRL, INSTR_SRA, INSTR_OR, INSTR_AND};
    assign is_branch = i_op inside {INSTR_BEQ, INSTR_BNE, INSTR_BLT, INSTR_BGE,
                                    INSTR_BLTU, INSTR_BGEU};
    assign is_jump   = i_op inside {INSTR_JAL, INSTR_JALR};
    assign is_upper  = i_op inside {INSTR_LUI, INSTR_AUIPC};
    assign csr_rw    = i_op inside {INSTR_CSRRW, INSTR_CSRRWI};
    assign csr_sc    = i_op inside {INSTR_CSRRS, INSTR_CSRRC, INSTR_CSRRSI, INSTR_CSRRCI};

    always_comb
    begin
        if (i_op == INSTR_JAL)
            o_imm = i_imms.imm_j;
        else if (is_upper)
            o_imm = i_imms.imm_u;
        else if (i_op == INSTR_JALR || is_load || is_op_imm)
            o_imm = i_imms.imm_i;
        else if (is_branch)
            o_imm = i_imms.imm_b;
        else if (is_store)
            o_imm = i_imms.imm_s;
        else
            o_imm = '0;
    end

    always_comb
    begin
        case (i_op)
            INSTR_BEQ:                            alu_op = ALU_EQ;
            INSTR_BNE:                            alu_op = ALU_NEQ;
            INSTR_BLT, INSTR_SLT, INSTR_SLTI:     alu_op = ALU_LTS;
            INSTR_BLTU, INSTR_SLTU, INSTR_SLTIU:  alu_op = ALU_LTU;
            INSTR_BGE:                            alu_op = ALU_NLTS;
            INSTR_BGEU:                           alu_op = ALU_NLTU;
            INSTR_SUB:                            alu_op = ALU_SUB;
            INSTR_XOR, INSTR_XORI:                alu_op = ALU_XOR;
            INSTR_OR, INSTR_ORI:                  alu_op = ALU_OR;
            INSTR_AND, INSTR_ANDI:                alu_op = ALU_AND;
            INSTR_SLL, INSTR_SLLI:                alu_op = ALU_SHL;
            INSTR_SRL, INSTR_SRLI:                alu_op = ALU_SHR_L;
            INSTR_SRA, INSTR_SRAI:                alu_op = ALU_SHR_A;
            // address and plain adds
            default:                              alu_op = ALU_ADD;
        endcase
    end

    always_comb
    begin
        o_ctrl.reg_write = is_load || is_op_imm || is_op || is_upper || is_jump;
        o_ctrl.mem_read  = is_load;
        o_ctrl.mem_write = is_store;
        if (is_load)
            o_ctrl.res_src = RES_MEMORY;
        else if (is_jump)
            o_ctrl.res_src = RES_PC_P4;
        else
            o_ctrl.res_src = RES_ALU;
        o_ctrl.jump      = is_jump;
        o_ctrl.branch    = is_branch;
        o_ctrl.pc_sel    = (i_op == INSTR_JALR);
        o_ctrl.op1_sel   = (i_op inside {INSTR_AUIPC, INSTR_JAL}) ? OP1_PC : OP1_REG;
        o_ctrl.op2_sel   = (is_upper || is_jump || is_op_imm || is_load || is_store) ?
                           OP2_IMM : OP2_REG;
        o_ctrl.funct3    = i_instr[14:12];
        o_ctrl.alu_ctrl  = alu_op;
        o_ctrl.csr_idx   = i_instr[31:20];
        // no read side effect for a write-only swap into x0
        o_ctrl.csr_read  = (csr_rw && (rd_f != '0)) || csr_sc;
        o_ctrl.csr_write = csr_rw || (csr_sc && (rs1_f != '0));
    end

    assign o_regs.rs1 = (i_op == INSTR_LUI) ? '0 : rs1_f;
    assign o_regs.rs2 = i_instr[24:20];
    assign o_regs.rd  = rd_f;

endmodule

//--- rv_decode.sv
`timescale 1ns/1ps

module rv_decode
    import rv_decode_pkg::*;
(
    input  logic            i_clk,
    input  logic            i_rst_n,
    input  logic            i_stall,
    input  logic            i_flush,
    input  logic [XLEN-1:0] i_instr,
    input  logic [PC_W-1:0] i_pc,
    input  logic [PC_W-1:0] i_pc_p4,
    output logic [PC_W-1:0] o_pc,
    output logic [PC_W-1:0] o_pc_p4,
    output reg_idx_t        o_regs,
    output logic [XLEN-1:0] o_imm,
    output decode_ctrl_t    o_ctrl,
    output logic            o_valid,
    output logic            o_illegal
);

    logic [PC_W-1:0] pc_q;
    logic [PC_W-1:0] pc_p4_q;
    logic            bubble_q;
    rv_instr_e       instr_op;
    imm_set_t        imms;

    // pc pair follows the fetched word into decode
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            pc_q    <= '0;
            pc_p4_q <= '0;
        end
        else if (i_flush)
        begin
            pc_q    <= '0;
            pc_p4_q <= '0;
        end
        else if (!i_stall)
        begin
            pc_q    <= i_pc;
            pc_p4_q <= i_pc_p4;
        end
    end

    // one bubble cycle after a flush, and out of reset
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
            bubble_q <= 1'b1;
        else
            bubble_q <= i_flush;
    end

    rv_instr_classify u_classify (
        .i_instr (i_instr),
        .o_instr (instr_op)
    );

    rv_imm_gen u_imm_gen (
        .i_instr (i_instr),
        .o_imms  (imms)
    );

    rv_ctrl_gen u_ctrl_gen (
        .i_instr (i_instr),
        .i_op    (instr_op),
        .i_imms  (imms),
        .o_regs  (o_regs),
        .o_imm   (o_imm),
        .o_ctrl  (o_ctrl)
    );

    assign o_pc      = pc_q;
    assign o_pc_p4   = pc_p4_q;
    assign o_valid   = !bubble_q;
    assign o_illegal = o_valid && (instr_op == INSTR_ILLEGAL);

endmodule

//--- rv_decode_props.sv
`timescale 1ns/1ps

module rv_decode_props
    import rv_decode_pkg::*;
(
    input logic         i_clk,
    input logic         i_rst_n,
    input logic         i_flush,
    input decode_ctrl_t i_ctrl,
    input logic         i_valid,
    input logic         i_illegal
);

    int assert_fail_count = 0;

    // an illegal word changes no state
    illegal_no_write: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_illegal |-> !(i_ctrl.reg_write || i_ctrl.mem_write || i_ctrl.csr_write))
    else
    begin
        $error("illegal instruction decoded with a write enable set");
        assert_fail_count = assert_fail_count + 1;
    end

    mem_rd_wr_excl: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_ctrl.mem_read && i_ctrl.mem_write))
    else
    begin
        $error("memory read and write both requested");
        assert_fail_count = assert_fail_count + 1;
    end

    // flush leaves a bubble
    flush_bubble: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_flush |=> !i_valid)
    else
    begin
        $error("o_valid high in the cycle after a flush");
        assert_fail_count = assert_fail_count + 1;
    end

endmodule

bind rv_decode rv_decode_props u_props (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_flush   (i_flush),
    .i_ctrl    (o_ctrl),
    .i_valid   (o_valid),
    .i_illegal (o_illegal)
);

//--- tb_rv_decode_vectors.svh
`ifndef TB_RV_DECODE_VECTORS_SVH
`define TB_RV_DECODE_VECTORS_SVH

localparam int NUM_ROWS = 31;

// flags, msb first: reg_write mem_read mem_write | res_src | jump branch pc_sel
// | op1_sel op2_sel | csr_read csr_write
typedef struct packed {
    logic [31:0] instr;
    logic        stall;
    logic        flush;
    logic [31:0] imm;
    logic [11:0] flags;
    alu_ctrl_e   alu;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic        illegal;
} vec_row_t;

vec_row_t rows [NUM_ROWS];
int       row_count = 0;

task automatic add_row(input logic [31:0] instr, input logic [1:0] stall_flush,
                       input logic [31:0] imm, input logic [11:0] flags,
                       input alu_ctrl_e alu, input int rs1, input int rs2, input int rd,
                       input logic illegal);
    rows[row_count] = '{instr, stall_flush[1], stall_flush[0], imm, flags, alu,
                        rs1[4:0], rs2[4:0], rd[4:0], illegal};
    row_count++;
endtask

// instr, {stall, flush}, imm, flags, alu, rs1, rs2, rd, illegal
task automatic load_table();
    add_row(32'hFFC12083, 2'b00, 32'hFFFFFFFC, 12'b110_01_000_01_00, ALU_ADD, 2, 28, 1, 0);
    add_row(32'h00312423, 2'b00, 32'h00000008, 12'b001_00_000_01_00, ALU_ADD, 2, 3, 8, 0);
    add_row(32'hFFF10093, 2'b00, 32'hFFFFFFFF, 12'b100_00_000_01_00, ALU_ADD, 2, 31, 1, 0);
    add_row(32'h40515093, 2'b00, 32'h00000405, 12'b100_00_000_01_00, ALU_SHR_A, 2, 5, 1, 0);
    add_row(32'h003100B3, 2'b10, 32'h00000000, 12'b100_00_000_00_00, ALU_ADD, 2, 3, 1, 0);
    add_row(32'h403100B3, 2'b10, 32'h00000000, 12'b100_00_000_00_00, ALU_SUB, 2, 3, 1, 0);
    add_row(32'h403150B3, 2'b00, 32'h00000000, 12'b100_00_000_00_00, ALU_SHR_A, 2, 3, 1, 0);
    // lui keeps rs1 at zero although the raw field is 8
    add_row(32'h123450B7, 2'b01, 32'h12345000, 12'b100_00_000_01_00, ALU_ADD, 0, 3, 1, 0);
    add_row(32'hFFFFF097, 2'b00, 32'hFFFFF000, 12'b100_00_000_11_00, ALU_ADD, 31, 31, 1, 0);
    add_row(32'hFFDFF0EF, 2'b00, 32'hFFFFFFFC, 12'b100_10_100_11_00, ALU_ADD, 31, 29, 1, 0);
    add_row(32'h010100E7, 2'b00, 32'h00000010, 12'b100_10_101_01_00, ALU_ADD, 2, 16, 1, 0);
    add_row(32'h00310463, 2'b00, 32'h00000008, 12'b000_00_010_00_00, ALU_EQ, 2, 3, 8, 0);
    add_row(32'h00311463, 2'b00, 32'h00000008, 12'b000_00_010_00_00, ALU_NEQ, 2, 3, 8, 0);
    add_row(32'hFE314CE3, 2'b00, 32'hFFFFFFF8, 12'b000_00_010_00_00, ALU_LTS, 2, 3, 25, 0);
    add_row(32'h00315463, 2'b00, 32'h00000008, 12'b000_00_010_00_00, ALU_NLTS, 2, 3, 8, 0);
    add_row(32'h00316463, 2'b00, 32'h00000008, 12'b000_00_010_00_00, ALU_LTU, 2, 3, 8, 0);
    add_row(32'h00317463, 2'b00, 32'h00000008, 12'b000_00_010_00_00, ALU_NLTU, 2, 3, 8, 0);
    add_row(32'h0FF0000F, 2'b00, 32'h00000000, 12'b000_00_000_00_00, ALU_ADD, 0, 31, 0, 0);
    // compressed word, bad funct7, load funct3 3, ecall
    add_row(32'h00004501, 2'b00, 32'h00000000, 12'b000_00_000_00_00, ALU_ADD, 0, 0, 10, 1);
    add_row(32'h023100B3, 2'b00, 32'h00000000, 12'b000_00_000_00_00, ALU_ADD, 2, 3, 1, 1);
    add_row(32'hFFC13083, 2'b00, 32'h00000000, 12'b000_00_000_00_00, ALU_ADD, 2, 28, 1, 1);
    add_row(32'h00000073, 2'b00, 32'h00000000, 12'b000_00_000_00_00, ALU_ADD, 0, 0, 0, 1);
    // csr variants with rd and rs1 zero or not
    add_row(32'h300110F3, 2'b00, 32'h00000000, 12'b000_00_000_00_11, ALU_ADD, 2, 0, 1, 0);
    add_row(32'h30011073, 2'b00, 32'h00000000, 12'b000_00_000_00_01, ALU_ADD, 2, 0, 0, 0);
    add_row(32'h300020F3, 2'b00, 32'h00000000, 12'b000_00_000_00_10, ALU_ADD, 0, 0, 1, 0);
    add_row(32'h300120F3, 2'b00, 32'h00000000, 12'b000_00_000_00_11, ALU_ADD, 2, 0, 1, 0);
    add_row(32'h34113073, 2'b00, 32'h00000000, 12'b000_00_000_00_11, ALU_ADD, 2, 1, 0, 0);
    add_row(32'h3052D0F3, 2'b00, 32'h00000000, 12'b000_00_000_00_11, ALU_ADD, 5, 5, 1, 0);
    add_row(32'h3052D073, 2'b01, 32'h00000000, 12'b000_00_000_00_01, ALU_ADD, 5, 5, 0, 0);
    add_row(32'h300060F3, 2'b00, 32'h00000000, 12'b000_00_000_00_10, ALU_ADD, 0, 0, 1, 0);
    add_row(32'h3001F0F3, 2'b00, 32'h00000000, 12'b000_00_000_00_11, ALU_ADD, 3, 0, 1, 0);
endtask

`endif

//--- tb_rv_decode.sv
`timescale 1ns/1ps

module tb_rv_decode
    import rv_decode_pkg::*;
();

    logic            i_clk = 1'b0;
    logic            i_rst_n;
    logic            i_stall;
    logic            i_flush;
    logic [XLEN-1:0] i_instr;
    logic [PC_W-1:0] i_pc;
    logic [PC_W-1:0] i_pc_p4;
    logic [PC_W-1:0] o_pc;
    logic [PC_W-1:0] o_pc_p4;
    reg_idx_t        o_regs;
    logic [XLEN-1:0] o_imm;
    decode_ctrl_t    o_ctrl;
    logic            o_valid;
    logic            o_illegal;

    `include "tb_rv_decode_vectors.svh"

    localparam int CYCLE_LIMIT = 2 * NUM_ROWS + 20;

    int              cycle_count = 0;
    int              seed = 74562;
    logic            prev_stall;
    logic            prev_flush;
    logic [PC_W-1:0] prev_pc;
    logic [PC_W-1:0] prev_pc_p4;
    logic [PC_W-1:0] exp_pc;
    logic [PC_W-1:0] exp_pc_p4;
    logic            exp_valid;

    rv_decode u_rv_decode (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_stall   (i_stall),
        .i_flush   (i_flush),
        .i_instr   (i_instr),
        .i_pc      (i_pc),
        .i_pc_p4   (i_pc_p4),
        .o_pc      (o_pc),
        .o_pc_p4   (o_pc_p4),
        .o_regs    (o_regs),
        .o_imm     (o_imm),
        .o_ctrl    (o_ctrl),
        .o_valid   (o_valid),
        .o_illegal (o_illegal)
    );

    always #5 i_clk = ~i_clk;

    always @(posedge i_clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT)
        begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation failed");
            $fatal(1, "cycle limit reached");
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected)
        begin
            $display("error: %s got 0x%h expected 0x%h", name, got, expected);
            $display("Simulation failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    initial
    begin
        vec_row_t        row;
        logic [31:0]     rnd;
        logic [PC_W-1:0] new_pc;
        logic [11:0]     got_flags;
        i_rst_n    = 1'b0;
        i_stall    = 1'b0;
        i_flush    = 1'b1;
        // ecall on the bus stays masked by o_valid
        i_instr    = 32'h00000073;
        // nonzero so the first flush has a pc to clear
        i_pc       = 30'h2AAAAAAA;
        i_pc_p4    = 30'h2AAAAAAB;
        prev_stall = 1'b0;
        prev_flush = 1'b1;
        prev_pc    = '0;
        prev_pc_p4 = '0;
        exp_pc     = '0;
        exp_pc_p4  = '0;
        exp_valid  = 1'b0;
        load_table();
        repeat (2) @(posedge i_clk);
        i_rst_n <= 1'b1;
        @(negedge i_clk);
        check_value("o_valid", 32'(o_valid), 32'd0);
        check_value("o_illegal", 32'(o_illegal), 32'd0);
        check_value("o_pc", 32'(o_pc), 32'd0);
        for (int i = 0; i < NUM_ROWS; i++)
        begin
            row = rows[i];
            @(posedge i_clk);
            // expected registers follow the inputs seen at this edge
            if (prev_flush)
            begin
                exp_pc    = '0;
                exp_pc_p4 = '0;
                exp_valid = 1'b0;
            end
            else
            begin
                if (!prev_stall)
                begin
                    exp_pc    = prev_pc;
                    exp_pc_p4 = prev_pc_p4;
                end
                exp_valid = 1'b1;
            end
            rnd    = $random(seed);
            new_pc = rnd[PC_W-1:0];
            i_instr <= row.instr;
            i_stall <= row.stall;
            i_flush <= row.flush;
            i_pc    <= new_pc;
            i_pc_p4 <= new_pc + 1'b1;
            prev_stall = row.stall;
            prev_flush = row.flush;
            prev_pc    = new_pc;
            prev_pc_p4 = new_pc + 1'b1;
            @(negedge i_clk);
            got_flags = {o_ctrl.reg_write, o_ctrl.mem_read, o_ctrl.mem_write, o_ctrl.res_src,
                         o_ctrl.jump, o_ctrl.branch, o_ctrl.pc_sel,
                         o_ctrl.op1_sel, o_ctrl.op2_sel, o_ctrl.csr_read, o_ctrl.csr_write};
            check_value("o_imm", o_imm, row.imm);
            check_value("o_ctrl flags", 32'(got_flags), 32'(row.flags));
            check_value("o_ctrl.alu_ctrl", 32'(o_ctrl.alu_ctrl), 32'(row.alu));
            check_value("o_ctrl.funct3", 32'(o_ctrl.funct3), 32'(row.instr[14:12]));
            check_value("o_ctrl.csr_idx", 32'(o_ctrl.csr_idx), 32'(row.instr[31:20]));
            check_value("o_regs.rs1", 32'(o_regs.rs1), 32'(row.rs1));
            check_value("o_regs.rs2", 32'(o_regs.rs2), 32'(row.rs2));
            check_value("o_regs.rd", 32'(o_regs.rd), 32'(row.rd));
            check_value("o_valid", 32'(o_valid), 32'(exp_valid));
            check_value("o_illegal", 32'(o_illegal), 32'(exp_valid & row.illegal));
            check_value("o_pc", 32'(o_pc), 32'(exp_pc));
            check_value("o_pc_p4", 32'(o_pc_p4), 32'(exp_pc_p4));
        end
        // let the last cycle's assertions settle
        @(posedge i_clk);
        @(negedge i_clk);
        if (u_rv_decode.u_props.assert_fail_count == 0)
        begin
            $display("Simulation passed");
            $finish;
        end
        else
        begin
            $display("Simulation failed");
            $fatal(1, "%0d assertion failures", u_rv_decode.u_props.assert_fail_count);
        end
    end

endmodule

//--- sources.f
+incdir+.
rv_decode_pkg.sv
rv_instr_classify.sv
rv_imm_gen.sv
rv_ctrl_gen.sv
rv_decode.sv
rv_decode_props.sv
tb_rv_decode.sv
